// File: design/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// cache geometry
`define CACHE_SETS      4
`define CACHE_WAYS      2
`define WORDS_PER_LINE  4

// word and address widths
`define WORD_W          32
`define ADDR_W          30   // processor word address
`define TAG_W           26   // addr minus index and offset

// line width is WORDS_PER_LINE * WORD_W, the memory transfer unit
// line address is the word address with the offset dropped

`endif

// File: design/cache_pkg.sv
`default_nettype none

`include "cache_params.svh"

package cache_pkg;

    localparam int unsigned INDEX_W  = $clog2(`CACHE_SETS);
    localparam int unsigned OFFSET_W = $clog2(`WORDS_PER_LINE);

    typedef logic [`WORD_W-1:0]                 word_t;
    typedef logic [`WORDS_PER_LINE*`WORD_W-1:0] line_data_t;
    typedef logic [`TAG_W-1:0]                  tag_t;
    typedef logic [`ADDR_W-OFFSET_W-1:0]        line_addr_t;   // tag and index
    typedef logic [$clog2(`CACHE_WAYS)-1:0]     way_sel_t;

    typedef struct packed {
        tag_t                tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;    // word n sits at bit 32n of the line
    } proc_addr_t;

    typedef struct packed {
        logic       valid;
        logic       lru;    // set on the most recently written way
        tag_t       tag;
        line_data_t data;
    } cache_line_t;

    typedef struct packed {
        logic       read;
        logic       write;
        proc_addr_t addr;
        word_t      wdata;
    } proc_req_t;

    typedef struct packed {
        logic       read;
        logic       write;
        line_addr_t addr;
        line_data_t wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// File: design/cache_set_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_params.svh"

module cache_set_array (
    input  wire                         clk,
    input  wire                         proc_reset,
    input  wire cache_pkg::proc_addr_t  addr,
    input  wire                         wr_en,
    input  wire cache_pkg::way_sel_t    wr_way,
    input  wire cache_pkg::cache_line_t wr_line,
    output logic                        hit,
    output cache_pkg::way_sel_t         hit_way,
    output cache_pkg::way_sel_t         victim_way,
    output cache_pkg::cache_line_t      way_lines [`CACHE_WAYS]
);
    import cache_pkg::*;

    logic       valid_q [`CACHE_SETS][`CACHE_WAYS];
    logic       lru_q   [`CACHE_SETS][`CACHE_WAYS];
    tag_t       tag_q   [`CACHE_SETS][`CACHE_WAYS];
    line_data_t data_q  [`CACHE_SETS][`CACHE_WAYS];

    // valid and lru bits, cleared on reset
    always_ff @(posedge clk) begin
        if (proc_reset) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    valid_q[s][w] <= 1'b0;
                    lru_q[s][w]   <= 1'b0;
                end
            end
        end else if (wr_en) begin
            valid_q[addr.index][wr_way] <= wr_line.valid;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                lru_q[addr.index][w] <= (way_sel_t'(w) == wr_way);   // written way is newest
            end
        end
    end

    // tag and data storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[addr.index][wr_way]  <= wr_line.tag;
            data_q[addr.index][wr_way] <= wr_line.data;
        end
    end

    // lines of the indexed set
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_lines[w].valid = valid_q[addr.index][w];
            way_lines[w].lru   = lru_q[addr.index][w];
            way_lines[w].tag   = tag_q[addr.index][w];
            way_lines[w].data  = data_q[addr.index][w];
        end
    end

    // tag compare, lowest matching way wins
    always_comb begin
        logic found;
        found   = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!found && way_lines[w].valid && (way_lines[w].tag == addr.tag)) begin
                found   = 1'b1;
                hit_way = way_sel_t'(w);
            end
        end
        hit = found;
    end

    // victim choice: first empty way, otherwise the way with lru clear
    always_comb begin
        logic empty_found;
        logic old_found;
        empty_found = 1'b0;
        old_found   = 1'b0;
        victim_way  = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!empty_found && !way_lines[w].valid) begin
                empty_found = 1'b1;
                victim_way  = way_sel_t'(w);
            end
        end
        if (!empty_found) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (!old_found && !way_lines[w].lru) begin
                    old_found  = 1'b1;
                    victim_way = way_sel_t'(w);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/cache_line_update.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_params.svh"

module cache_line_update (
    input  wire cache_pkg::proc_req_t   req,
    input  wire cache_pkg::cache_line_t hit_line,
    input  wire cache_pkg::line_data_t  mem_rdata,
    output cache_pkg::word_t            hit_word,
    output cache_pkg::word_t            fill_word,
    output cache_pkg::cache_line_t      merged_line,
    output cache_pkg::cache_line_t      fill_line
);
    import cache_pkg::*;

    localparam int unsigned WORD_BITS = $bits(word_t);

    // offset mux over the words of a line
    function automatic word_t pick_word(
        input line_data_t          data,
        input logic [OFFSET_W-1:0] offset
    );
        word_t w;
        w = '0;
        for (int n = 0; n < `WORDS_PER_LINE; n++) begin
            if (int'(offset) == n) begin
                w = data[n*WORD_BITS +: WORD_BITS];
            end
        end
        return w;
    endfunction

    // replace one word, keep the rest of the line
    function automatic line_data_t put_word(
        input line_data_t          data,
        input logic [OFFSET_W-1:0] offset,
        input word_t               w
    );
        line_data_t d;
        d = data;
        for (int n = 0; n < `WORDS_PER_LINE; n++) begin
            if (int'(offset) == n) begin
                d[n*WORD_BITS +: WORD_BITS] = w;
            end
        end
        return d;
    endfunction

    assign hit_word  = pick_word(hit_line.data, req.addr.offset);
    assign fill_word = pick_word(mem_rdata, req.addr.offset);   // read miss data

    // hit line, with the write word on a write
    always_comb begin
        merged_line = hit_line;
        if (req.write) begin
            merged_line.data = put_word(hit_line.data, req.addr.offset, req.wdata);
        end
    end

    // refill line from memory, write word merged for write-allocate
    always_comb begin
        fill_line.valid = 1'b1;
        fill_line.lru   = 1'b1;
        fill_line.tag   = req.addr.tag;
        fill_line.data  = mem_rdata;
        if (req.write) begin
            fill_line.data = put_word(mem_rdata, req.addr.offset, req.wdata);
        end
    end

endmodule

`default_nettype wire

// File: design/cache_controller.sv
`timescale 1ns/100ps
`default_nettype none

module cache_controller (
    input  wire                         clk,
    input  wire                         proc_reset,
    input  wire cache_pkg::proc_req_t   req,
    input  wire                         hit,
    input  wire cache_pkg::way_sel_t    hit_way,
    input  wire cache_pkg::way_sel_t    victim_way,
    input  wire cache_pkg::cache_line_t merged_line,
    input  wire cache_pkg::cache_line_t fill_line,
    input  wire                         mem_ready,
    output logic                        proc_stall,
    output logic                        use_fill_word,
    output cache_pkg::mem_req_t         mem_req,
    output logic                        wr_en,
    output cache_pkg::way_sel_t         wr_way,
    output cache_pkg::cache_line_t      wr_line
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RD_REFILL,   // read miss, waiting for the line
        ST_WR_REFILL,   // write miss, waiting for the line
        ST_WR_THRU      // merged line going out to memory
    } state_t;

    state_t     state_q;
    state_t     state_d;
    logic       mem_read_q;
    logic       mem_read_d;
    logic       mem_write_q;
    logic       mem_write_d;
    line_addr_t mem_addr_q;
    line_data_t mem_wdata_q;
    logic       addr_load;
    logic       wdata_load;
    line_addr_t req_line;

    assign req_line = {req.addr.tag, req.addr.index};

    always_comb begin
        state_d       = state_q;
        mem_read_d    = mem_read_q;
        mem_write_d   = mem_write_q;
        addr_load     = 1'b0;
        wdata_load    = 1'b0;
        proc_stall    = 1'b0;
        use_fill_word = 1'b0;
        wr_en         = 1'b0;
        wr_way        = hit_way;
        wr_line       = merged_line;

        case (state_q)
            ST_IDLE: begin
                if (req.read) begin
                    if (hit) begin
                        wr_en = 1'b1;   // rewrite same line to refresh lru
                    end else begin
                        proc_stall = 1'b1;
                        mem_read_d = 1'b1;
                        addr_load  = 1'b1;
                        state_d    = ST_RD_REFILL;
                    end
                end else if (req.write) begin
                    proc_stall = 1'b1;
                    addr_load  = 1'b1;
                    if (hit) begin
                        wr_en       = 1'b1;   // merged line stored now
                        mem_write_d = 1'b1;
                        wdata_load  = 1'b1;
                        state_d     = ST_WR_THRU;
                    end else begin
                        mem_read_d = 1'b1;
                        state_d    = ST_WR_REFILL;
                    end
                end
            end

            ST_RD_REFILL: begin
                proc_stall    = !mem_ready;   // data comes straight from memory
                use_fill_word = 1'b1;
                wr_way        = victim_way;
                wr_line       = fill_line;
                if (mem_ready) begin
                    wr_en      = 1'b1;
                    mem_read_d = 1'b0;
                    state_d    = ST_IDLE;
                end
            end

            ST_WR_REFILL: begin
                proc_stall = 1'b1;
                wr_way     = victim_way;
                wr_line    = fill_line;   // already holds the write word
                if (mem_ready) begin
                    wr_en       = 1'b1;
                    mem_read_d  = 1'b0;
                    mem_write_d = 1'b1;
                    wdata_load  = 1'b1;
                    state_d     = ST_WR_THRU;
                end
            end

            ST_WR_THRU: begin
                proc_stall = !mem_ready;
                if (mem_ready) begin
                    mem_write_d = 1'b0;
                    state_d     = ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state_q     <= ST_IDLE;
            mem_read_q  <= 1'b0;
            mem_write_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            mem_read_q  <= mem_read_d;
            mem_write_q <= mem_write_d;
        end
    end

    // request payload, held until mem_ready
    always_ff @(posedge clk) begin
        if (addr_load) begin
            mem_addr_q <= req_line;
        end
        if (wdata_load) begin
            mem_wdata_q <= wr_line.data;
        end
    end

    always_comb begin
        mem_req.read  = mem_read_q;
        mem_req.write = mem_write_q;
        mem_req.addr  = mem_addr_q;
        mem_req.wdata = mem_wdata_q;
    end

endmodule

`default_nettype wire

// File: design/cache_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_params.svh"

module cache_top (
    input  wire                        clk,
    input  wire                        proc_reset,
    input  wire cache_pkg::proc_req_t  proc_req,
    input  wire cache_pkg::line_data_t mem_rdata,
    input  wire                        mem_ready,
    output cache_pkg::word_t           proc_rdata,
    output logic                       proc_stall,
    output cache_pkg::mem_req_t        mem_req
);
    import cache_pkg::*;

    logic        hit;
    way_sel_t    hit_way;
    way_sel_t    victim_way;
    cache_line_t way_lines [`CACHE_WAYS];
    logic        wr_en;
    way_sel_t    wr_way;
    cache_line_t wr_line;
    cache_line_t merged_line;
    cache_line_t fill_line;
    word_t       hit_word;
    word_t       fill_word;
    logic        use_fill_word;

    cache_set_array set_array_i (
        .clk        (clk),
        .proc_reset (proc_reset),
        .addr       (proc_req.addr),
        .wr_en      (wr_en),
        .wr_way     (wr_way),
        .wr_line    (wr_line),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .way_lines  (way_lines)
    );

    cache_line_update line_update_i (
        .req         (proc_req),
        .hit_line    (way_lines[hit_way]),
        .mem_rdata   (mem_rdata),
        .hit_word    (hit_word),
        .fill_word   (fill_word),
        .merged_line (merged_line),
        .fill_line   (fill_line)
    );

    cache_controller controller_i (
        .clk           (clk),
        .proc_reset    (proc_reset),
        .req           (proc_req),
        .hit           (hit),
        .hit_way       (hit_way),
        .victim_way    (victim_way),
        .merged_line   (merged_line),
        .fill_line     (fill_line),
        .mem_ready     (mem_ready),
        .proc_stall    (proc_stall),
        .use_fill_word (use_fill_word),
        .mem_req       (mem_req),
        .wr_en         (wr_en),
        .wr_way        (wr_way),
        .wr_line       (wr_line)
    );

    assign proc_rdata = use_fill_word ? fill_word : hit_word;   // refill bypass

endmodule

`default_nettype wire

// File: testbench/tb_cache_mem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cache_mem (
    input  wire                        clk,
    input  wire                        proc_reset,
    input  wire cache_pkg::mem_req_t   mem_req,
    input  wire                        long_delay,
    output cache_pkg::line_data_t      mem_rdata,
    output logic                       mem_ready,
    output int                         read_count,
    output int                         write_count,
    output cache_pkg::line_addr_t      last_waddr,
    output cache_pkg::line_data_t      last_wdata,
    output logic                       req_stable
);
    import cache_pkg::*;

    line_data_t  lines [line_addr_t];   // only lines written so far
    logic [31:0] lfsr_q;
    int          wait_cnt;
    mem_req_t    held_req;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per delay bit
    task automatic draw_delay(output int d);
        int nbits;
        d     = 0;
        nbits = long_delay ? 4 : 2;
        for (int i = 0; i < nbits; i++) begin
            d      = (d << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic line_data_t default_line(input line_addr_t a);
        line_data_t d;
        for (int n = 0; n < 4; n++) begin
            d[n*32 +: 32] = word_t'({a, 2'(n)}) ^ 32'h5a5a0000;   // addr*4 + n
        end
        return d;
    endfunction

    initial begin
        mem_ready   = 1'b0;
        mem_rdata   = '0;
        read_count  = 0;
        write_count = 0;
        last_waddr  = '0;
        last_wdata  = '0;
        req_stable  = 1'b1;
        lfsr_q      = 32'hac72bdff;
        wait_cnt    = -1;
        forever begin
            @(negedge clk);
            mem_ready = 1'b0;
            if (proc_reset) begin
                wait_cnt = -1;
            end else if (mem_req.read || mem_req.write) begin
                if (wait_cnt < 0) begin
                    draw_delay(wait_cnt);   // new request
                    held_req = mem_req;
                end else if (mem_req !== held_req) begin
                    req_stable = 1'b0;   // changed while waiting
                end
                if (wait_cnt == 0) begin
                    mem_ready = 1'b1;
                    wait_cnt  = -1;
                    if (mem_req.read) begin
                        mem_rdata = lines.exists(mem_req.addr) ? lines[mem_req.addr]
                                                               : default_line(mem_req.addr);
                        read_count++;
                    end else begin
                        lines[mem_req.addr] = mem_req.wdata;
                        last_waddr          = mem_req.addr;
                        last_wdata          = mem_req.wdata;
                        write_count++;
                    end
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_cache_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_params.svh"

module tb_cache_top;
    import cache_pkg::*;

    localparam int TIMEOUT = 200;

    logic       clk;
    logic       proc_reset;
    logic       long_delay;
    proc_req_t  proc_req;
    word_t      proc_rdata;
    logic       proc_stall;
    mem_req_t   mem_req;
    line_data_t mem_rdata;
    logic       mem_ready;
    int         read_count;
    int         write_count;
    line_addr_t last_waddr;
    line_data_t last_wdata;
    logic       req_stable;

    logic       sh_valid [`CACHE_SETS][`CACHE_WAYS];   // shadow of the tag store
    logic       sh_lru   [`CACHE_SETS][`CACHE_WAYS];
    tag_t       sh_tag   [`CACHE_SETS][`CACHE_WAYS];
    line_data_t exp_lines [line_addr_t];               // expected memory image

    cache_top dut_i (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_req   (proc_req),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall),
        .mem_req    (mem_req)
    );

    tb_cache_mem mem_i (
        .clk         (clk),
        .proc_reset  (proc_reset),
        .mem_req     (mem_req),
        .long_delay  (long_delay),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .read_count  (read_count),
        .write_count (write_count),
        .last_waddr  (last_waddr),
        .last_wdata  (last_wdata),
        .req_stable  (req_stable)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic compare_line(input string name, input line_data_t got, input line_data_t exp);
        if (got !== exp) fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic compare_line_addr(input string name, input line_addr_t got,
                                     input line_addr_t exp);
        if (got !== exp) fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    function automatic proc_addr_t make_addr(input tag_t t, input int idx, input int off);
        proc_addr_t a;
        a.tag    = t;
        a.index  = 2'(idx);
        a.offset = 2'(off);
        return a;
    endfunction

    // word n of an unwritten line is its line address * 4 + n xored with 5a5a0000
    function automatic line_data_t expected_line(input line_addr_t la);
        line_data_t d;
        if (exp_lines.exists(la)) return exp_lines[la];
        for (int n = 0; n < `WORDS_PER_LINE; n++) begin
            d[n*32 +: 32] = (32'(la) * 4 + n) ^ 32'h5a5a0000;
        end
        return d;
    endfunction

    // hit lookup first, then empty way 0, then empty way 1, then the way with lru clear
    task automatic update_shadow(input proc_addr_t a, output bit was_hit);
        int way;
        way     = -1;
        was_hit = 1'b0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (way < 0 && sh_valid[a.index][w] && sh_tag[a.index][w] == a.tag) way = w;
        end
        was_hit = (way >= 0);
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (way < 0 && !sh_valid[a.index][w]) way = w;
        end
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (way < 0 && !sh_lru[a.index][w]) way = w;
        end
        sh_valid[a.index][way] = 1'b1;
        sh_tag[a.index][way]   = a.tag;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            sh_lru[a.index][w] = (w == way);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        proc_reset = 1'b1;
        proc_req   = '0;
        repeat (3) @(negedge clk);
        proc_reset = 1'b0;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                sh_valid[s][w] = 1'b0;
                sh_lru[s][w]   = 1'b0;
            end
        end
    endtask

    // one processor request is held until proc_stall is low
    task automatic access(input bit is_write, input proc_addr_t a, input word_t wdata,
                          output word_t rdata, output int stalls);
        bit done;
        done   = 1'b0;
        stalls = 0;
        rdata  = '0;
        @(negedge clk);
        proc_req.read  = !is_write;
        proc_req.write = is_write;
        proc_req.addr  = a;
        proc_req.wdata = wdata;
        for (int t = 0; t < TIMEOUT && !done; t++) begin
            #1;
            if (!proc_stall) begin
                rdata = proc_rdata;
                done  = 1'b1;
            end else begin
                stalls++;
                @(negedge clk);
            end
        end
        if (!done) fail_now("timeout: proc_stall stayed high");
        @(posedge clk);   // accepting edge
        @(negedge clk);
        proc_req.read  = 1'b0;
        proc_req.write = 1'b0;
    endtask

    task automatic read_check(input proc_addr_t a, output bit was_hit);
        line_addr_t la;
        line_data_t l;
        word_t      got;
        int         r0;
        int         w0;
        int         stalls;
        la = {a.tag, a.index};
        r0 = read_count;
        w0 = write_count;
        update_shadow(a, was_hit);
        access(1'b0, a, '0, got, stalls);
        l = expected_line(la);
        compare_word("proc_rdata", got, l[a.offset*32 +: 32]);
        compare_count("memory reads", read_count - r0, was_hit ? 0 : 1);
        compare_count("memory writes", write_count - w0, 0);
        if (was_hit) compare_count("read hit stall cycles", stalls, 0);
    endtask

    task automatic write_check(input proc_addr_t a, input word_t wdata, output bit was_hit);
        line_addr_t la;
        line_data_t l;
        word_t      got;
        int         r0;
        int         w0;
        int         stalls;
        la = {a.tag, a.index};
        r0 = read_count;
        w0 = write_count;
        update_shadow(a, was_hit);
        l                  = expected_line(la);
        l[a.offset*32 +: 32] = wdata;   // merged line goes to memory
        exp_lines[la]      = l;
        access(1'b1, a, wdata, got, stalls);
        compare_count("memory reads", read_count - r0, was_hit ? 0 : 1);
        compare_count("memory writes", write_count - w0, 1);
        compare_line_addr("mem_req.addr", last_waddr, la);
        compare_line("mem_req.wdata", last_wdata, l);
    endtask

    task automatic test_cold_read();
        bit h;
        read_check(make_addr(26'h0000123, 1, 2), h);
        compare_count("cold read hit", h, 0);
        read_check(make_addr(26'h0000123, 1, 3), h);
        compare_count("same line read hit", h, 1);
    endtask

    task automatic test_write_hit();
        bit h;
        write_check(make_addr(26'h0000123, 1, 0), 32'hdeadbeef, h);
        compare_count("write hit", h, 1);
        read_check(make_addr(26'h0000123, 1, 0), h);
        compare_count("read after write hit", h, 1);
    endtask

    task automatic test_write_miss();
        bit h;
        write_check(make_addr(26'h0000456, 3, 1), 32'h13579bdf, h);
        compare_count("write miss hit", h, 0);
        read_check(make_addr(26'h0000456, 3, 2), h);
        compare_count("neighbor read hit", h, 1);
    endtask

    task automatic test_lru();
        bit h;
        read_check(make_addr(26'h0000a0a, 2, 0), h);   // A
        read_check(make_addr(26'h0000b0b, 2, 1), h);   // B
        read_check(make_addr(26'h0000a0a, 2, 2), h);   // A again
        read_check(make_addr(26'h0000c0c, 2, 3), h);   // C evicts B
        read_check(make_addr(26'h0000a0a, 2, 3), h);
        compare_count("lru read of A hit", h, 1);
        read_check(make_addr(26'h0000b0b, 2, 0), h);
        compare_count("lru read of B hit", h, 0);
    endtask

    task automatic test_backpressure_reset();
        bit         h;
        proc_addr_t a;
        line_addr_t la;
        long_delay = 1'b1;
        read_check(make_addr(26'h0000777, 0, 1), h);
        write_check(make_addr(26'h0000888, 0, 2), 32'hcafef00d, h);
        write_check(make_addr(26'h0000777, 0, 3), 32'h0badf00d, h);
        read_check(make_addr(26'h0000999, 0, 0), h);
        compare_count("request stable under back-pressure", req_stable, 1);
        long_delay = 1'b0;
        // reset lands while a refill is still in flight
        a  = make_addr(26'h0000aaa, 0, 1);
        la = {a.tag, a.index};
        @(negedge clk);
        proc_req.read  = 1'b1;
        proc_req.write = 1'b0;
        proc_req.addr  = a;
        proc_req.wdata = '0;
        @(posedge clk);
        #1;
        compare_count("mem_req.read on a miss", mem_req.read, 1);
        compare_line_addr("mem_req.addr", mem_req.addr, la);
        compare_count("proc_stall on a miss", proc_stall, 1);
        apply_reset();
        #1;
        compare_count("mem_req.read after reset", mem_req.read, 0);
        compare_count("mem_req.write after reset", mem_req.write, 0);
        compare_count("proc_stall after reset", proc_stall, 0);
        read_check(make_addr(26'h0000777, 0, 3), h);
        compare_count("read after reset hit", h, 0);
    endtask

    initial begin
        proc_reset = 1'b1;
        long_delay = 1'b0;
        proc_req   = '0;
        apply_reset();
        test_cold_read();
        test_write_hit();
        test_write_miss();
        test_lru();
        test_backpressure_reset();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: cache_top.f
+incdir+design
design/cache_pkg.sv
design/cache_set_array.sv
design/cache_line_update.sv
design/cache_controller.sv
design/cache_top.sv
testbench/tb_cache_mem.sv
testbench/tb_cache_top.sv
